/* rtl/dramPkg.sv */
// Word constants, DRAM command and sequencer state enums, request, response and DRAM bus structs
`default_nettype none

package dramPkg;

  localparam int wordBits = 32;
  localparam int byteLanes = 4;
  localparam int maxAddrBits = 16; // Row and column, right-aligned

  // Command carried on the device pins
  typedef enum logic [2:0] {
    nop,
    precharge,
    activate,
    read,
    write
  } dramCmd;

  typedef enum logic [2:0] {
    idle,
    prechargeWait,
    activateWait,
    columnWait,
    finish
  } seqState;

  typedef struct packed {
    logic write;
    logic [byteLanes-1:0] byteEn; // Active high
    logic [maxAddrBits-1:0] addr;
    logic [wordBits-1:0] wdata;
  } memReq;

  typedef struct packed {
    logic done; // One-cycle pulse
    logic [wordBits-1:0] rdata;
  } memRsp;

  typedef struct packed {
    logic csn;
    logic rasn;
    logic casn;
    logic [byteLanes-1:0] wen; // Active low per byte
    logic [maxAddrBits-1:0] a; // Row or column
    logic [wordBits-1:0] d;
  } dramBus;

endpackage

`default_nettype wire

/* rtl/dramDevice.sv */
// Behavioral single-bank DRAM with precharge, row and column delay counters and byte-lane array
`timescale 1ns/1ns
`default_nettype none

module dramDevice #(
  parameter int rowBits = 4,
  parameter int colBits = 5
) (
  input  logic RST,
  input  logic CK,
  input  dramPkg::dramBus bus,
  output logic [dramPkg::wordBits-1:0] q,
  output logic valid
);

  localparam int addrBits = rowBits + colBits;
  localparam int memWords = 1 << addrBits;
  localparam int laneBits = dramPkg::wordBits / dramPkg::byteLanes;

  logic [dramPkg::byteLanes-1:0][laneBits-1:0] mem [memWords];
  logic [2:0] precharge;
  logic [2:0] rowDelay;
  logic [2:0] colDelay;
  logic [rowBits-1:0] rowLatch;
  logic [addrBits-1:0] addrLatch;
  logic [dramPkg::byteLanes-1:0] wenLatch;
  logic isPre;
  logic isAct;
  logic isCol;

  // Pin-level command decode
  assign isPre = !bus.csn && !bus.rasn && bus.casn && (bus.wen == '0);
  assign isAct = !bus.csn && !bus.rasn && bus.casn && (bus.wen == '1);
  assign isCol = !bus.csn && bus.rasn && !bus.casn;

  always_ff @(posedge RST or posedge CK) begin
    if (CK) begin
      precharge <= 3'd5; // Device starts precharged
    end else if (rowDelay == 3'd1) begin
      precharge <= 3'd0; // Row opened, bank no longer precharged
    end else if (precharge > 3'd0 && precharge < 3'd5) begin
      precharge <= precharge + 3'd1;
    end else if (isPre) begin
      precharge <= 3'd1;
    end
  end

  always_ff @(posedge RST or posedge CK) begin
    if (CK) begin
      rowDelay <= 3'd0;
      rowLatch <= '0;
    end else if (rowDelay > 3'd0 && rowDelay < 3'd5) begin
      rowDelay <= rowDelay + 3'd1;
    end else if (isAct && precharge == 3'd5) begin
      rowLatch <= bus.a[rowBits-1:0];
      rowDelay <= 3'd1;
    end else if (isPre) begin
      rowDelay <= 3'd0; // Row closed
    end
  end

  always_ff @(posedge RST or posedge CK) begin
    if (CK) begin
      colDelay <= 3'd0;
      addrLatch <= '0;
      wenLatch <= '1;
    end else if (colDelay > 3'd3) begin
      colDelay <= 3'd0;
    end else if (colDelay > 3'd0) begin
      colDelay <= colDelay + 3'd1;
    end else if (isCol && rowDelay == 3'd5) begin
      addrLatch <= {rowLatch, bus.a[colBits-1:0]};
      wenLatch <= bus.wen;
      colDelay <= 3'd1;
    end
  end

  // Byte-lane write at the end of the column delay
  always_ff @(posedge RST or posedge CK) begin
    if (CK) begin
      for (int i = 0; i < memWords; i++) begin
        mem[i] <= '0;
      end
    end else if (!bus.csn && colDelay == 3'd4) begin
      for (int l = 0; l < dramPkg::byteLanes; l++) begin
        if (!wenLatch[l]) begin
          mem[addrLatch][l] <= bus.d[l*laneBits +: laneBits];
        end
      end
    end
  end

  always_ff @(posedge RST or posedge CK) begin
    if (CK) begin
      q <= '0;
      valid <= 1'b0;
    end else if (!bus.csn && colDelay == 3'd4 && wenLatch == '1) begin
      q <= mem[addrLatch];
      valid <= 1'b1;
    end else begin
      q <= '0; // Nothing shares the data wires
      valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/dramSequencer.sv */
// Command sequencer tracking the open row and issuing precharge, activate and column commands
`timescale 1ns/1ns
`default_nettype none

module dramSequencer #(
  parameter int rowBits = 4,
  parameter int colBits = 5
) (
  input  logic RST,
  input  logic CK,
  input  logic start,
  input  dramPkg::memReq req,
  output logic busy,
  output dramPkg::memRsp rsp,
  output dramPkg::dramBus bus,
  input  logic [dramPkg::wordBits-1:0] q,
  input  logic valid
);

  dramPkg::seqState state;
  dramPkg::dramCmd cmd;
  dramPkg::memReq reqReg;
  logic [2:0] cnt;
  logic csnReg;
  logic rowOpen;
  logic [rowBits-1:0] openRow;
  logic [rowBits-1:0] inRow;
  logic [rowBits-1:0] reqRow;
  logic [colBits-1:0] reqCol;
  logic [dramPkg::wordBits-1:0] rdataReg;

  assign inRow = req.addr[colBits +: rowBits];
  assign reqRow = reqReg.addr[colBits +: rowBits];
  assign reqCol = reqReg.addr[colBits-1:0];

  assign busy = (state != dramPkg::idle);
  assign rsp.done = (state == dramPkg::finish);
  assign rsp.rdata = rdataReg;

  always_ff @(posedge RST or posedge CK) begin
    if (CK) begin
      state <= dramPkg::idle;
      cmd <= dramPkg::nop;
      cnt <= 3'd0;
      csnReg <= 1'b1;
      rowOpen <= 1'b0;
      openRow <= '0;
    end else begin
      cmd <= dramPkg::nop; // Every command lasts one cycle
      case (state)
        dramPkg::idle: begin
          if (start) begin
            csnReg <= 1'b0;
            cnt <= 3'd0;
            if (rowOpen && inRow == openRow) begin
              cmd <= req.write ? dramPkg::write : dramPkg::read;
              state <= dramPkg::columnWait;
            end else if (rowOpen) begin
              cmd <= dramPkg::precharge;
              state <= dramPkg::prechargeWait;
            end else begin
              cmd <= dramPkg::activate; // Device is already precharged
              openRow <= inRow;
              rowOpen <= 1'b1;
              state <= dramPkg::activateWait;
            end
          end
        end
        dramPkg::prechargeWait: begin
          if (cnt == 3'd4) begin
            cmd <= dramPkg::activate;
            openRow <= reqRow;
            cnt <= 3'd0;
            state <= dramPkg::activateWait;
          end else begin
            cnt <= cnt + 3'd1;
          end
        end
        dramPkg::activateWait: begin
          if (cnt == 3'd4) begin
            cmd <= reqReg.write ? dramPkg::write : dramPkg::read;
            cnt <= 3'd0;
            state <= dramPkg::columnWait;
          end else begin
            cnt <= cnt + 3'd1;
          end
        end
        dramPkg::columnWait: begin
          // Write lands on the device four cycles after the column command
          if (reqReg.write ? (cnt == 3'd4) : valid) begin
            state <= dramPkg::finish;
          end
          if (cnt != 3'd7) begin
            cnt <= cnt + 3'd1;
          end
        end
        dramPkg::finish: state <= dramPkg::idle;
        default: state <= dramPkg::idle;
      endcase
    end
  end

  always_ff @(posedge RST) begin
    if (start && state == dramPkg::idle) begin
      reqReg <= req;
    end
    if (valid) begin
      rdataReg <= q;
    end
  end

  // Pin encoding of the current command
  always_comb begin
    bus.csn = csnReg;
    bus.rasn = 1'b1;
    bus.casn = 1'b1;
    bus.wen = '1;
    bus.a = '0;
    bus.d = reqReg.wdata;
    case (cmd)
      dramPkg::precharge: begin
        bus.rasn = 1'b0;
        bus.wen = '0;
        bus.a[rowBits-1:0] = openRow;
      end
      dramPkg::activate: begin
        bus.rasn = 1'b0;
        bus.a[rowBits-1:0] = reqRow;
      end
      dramPkg::read: begin
        bus.casn = 1'b0;
        bus.a[colBits-1:0] = reqCol;
      end
      dramPkg::write: begin
        bus.casn = 1'b0;
        bus.wen = ~reqReg.byteEn;
        bus.a[colBits-1:0] = reqCol;
      end
      default: begin
        bus.a = '0; // Nop keeps both strobes high
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/portArbiter.sv */
// Round-robin arbiter between two requester ports with response steering
`timescale 1ns/1ns
`default_nettype none

module portArbiter (
  input  logic RST,
  input  logic CK,
  input  dramPkg::memReq reqA,
  input  dramPkg::memReq reqB,
  input  logic validA,
  input  logic validB,
  input  logic busy,
  input  dramPkg::memRsp seqRsp,
  output logic start,
  output dramPkg::memReq grantReq,
  output dramPkg::memRsp rspA,
  output dramPkg::memRsp rspB
);

  logic granted;
  logic owner; // 1 means port B
  logic lastServed;
  logic pickB;

  // Other port first when both wait
  assign pickB = validB && (!validA || !lastServed);

  always_ff @(posedge RST or posedge CK) begin
    if (CK) begin
      granted <= 1'b0;
      owner <= 1'b0;
      lastServed <= 1'b1; // Port A goes first
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      if (granted) begin
        if (seqRsp.done) begin
          granted <= 1'b0;
          lastServed <= owner;
        end
      end else if (!busy && (validA || validB)) begin
        granted <= 1'b1;
        owner <= pickB;
        start <= 1'b1;
      end
    end
  end

  assign grantReq = owner ? reqB : reqA;

  always_comb begin
    rspA.done = seqRsp.done && granted && !owner;
    rspA.rdata = owner ? '0 : seqRsp.rdata;
    rspB.done = seqRsp.done && granted && owner;
    rspB.rdata = owner ? seqRsp.rdata : '0;
  end

endmodule

`default_nettype wire

/* rtl/memSubsystem.sv */
// Shared DRAM subsystem top with two requester ports, arbiter, sequencer and device
`timescale 1ns/1ns
`default_nettype none

module memSubsystem #(
  parameter int rowBits = 4,
  parameter int colBits = 5
) (
  input  logic RST,
  input  logic CK,
  input  dramPkg::memReq reqA,
  input  logic validA,
  input  dramPkg::memReq reqB,
  input  logic validB,
  output dramPkg::memRsp rspA,
  output dramPkg::memRsp rspB
);

  logic start;
  logic busy;
  dramPkg::memReq grantReq;
  dramPkg::memRsp seqRsp;
  dramPkg::dramBus bus;
  logic [dramPkg::wordBits-1:0] devQ;
  logic devValid;

  portArbiter arbiter (
    .RST(RST),
    .CK(CK),
    .reqA(reqA),
    .reqB(reqB),
    .validA(validA),
    .validB(validB),
    .busy(busy),
    .seqRsp(seqRsp),
    .start(start),
    .grantReq(grantReq),
    .rspA(rspA),
    .rspB(rspB)
  );

  dramSequencer #(.rowBits(rowBits), .colBits(colBits)) sequencer (
    .RST(RST),
    .CK(CK),
    .start(start),
    .req(grantReq),
    .busy(busy),
    .rsp(seqRsp),
    .bus(bus),
    .q(devQ),
    .valid(devValid)
  );

  dramDevice #(.rowBits(rowBits), .colBits(colBits)) device (
    .RST(RST),
    .CK(CK),
    .bus(bus),
    .q(devQ),
    .valid(devValid)
  );

endmodule

`default_nettype wire

/* verification/memSubsystemTb.sv */
// Testbench for memSubsystem with golden-file stimulus, reference memory, port contention and summary
`timescale 1ns/1ns
`default_nettype none

module memSubsystemTb;

  localparam int rowBits = 4;
  localparam int colBits = 5;
  localparam int addrBits = rowBits + colBits;
  localparam int memWords = 1 << addrBits;
  localparam int doneTimeout = 200;

  logic RST;
  logic CK;
  dramPkg::memReq reqA;
  dramPkg::memReq reqB;
  logic validA;
  logic validB;
  dramPkg::memRsp rspA;
  dramPkg::memRsp rspB;

  logic pendA; // Request outstanding on port A
  logic pendB;
  int mismatches;
  int failures;
  logic [31:0] rngState;
  logic [31:0] refMem [memWords];

  memSubsystem #(.rowBits(rowBits), .colBits(colBits)) DUT (
    .RST(RST),
    .CK(CK),
    .reqA(reqA),
    .validA(validA),
    .reqB(reqB),
    .validB(validB),
    .rspA(rspA),
    .rspB(rspB)
  );

  always #10 RST = ~RST;

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int l = 0; l < 4; l++) begin
      if (be[l]) res[l*8 +: 8] = data[l*8 +: 8]; // Enabled lanes only
    end
    return res;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] expd);
    if (got !== expd) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expd);
      mismatches++;
    end
  endtask

  // Hold the request level until done, then release it
  task automatic doTransaction(input logic portB, input dramPkg::memReq req,
                               input logic [31:0] expd, input logic checkData);
    int cycles;
    logic seen;
    logic [31:0] got;
    seen = 1'b0;
    cycles = 0;
    got = '0;
    @(posedge RST);
    if (portB) begin
      reqB <= req;
      validB <= 1'b1;
      pendB <= 1'b1;
    end else begin
      reqA <= req;
      validA <= 1'b1;
      pendA <= 1'b1;
    end
    while (!seen && cycles < doneTimeout) begin
      @(negedge RST);
      cycles++;
      if (portB ? rspB.done : rspA.done) begin
        seen = 1'b1;
        got = portB ? rspB.rdata : rspA.rdata;
      end
    end
    @(posedge RST);
    if (portB) begin
      validB <= 1'b0;
      pendB <= 1'b0;
    end else begin
      validA <= 1'b0;
      pendA <= 1'b0;
    end
    if (!seen) begin
      $display("Timeout at %0t ns: port %s saw no done within %0d cycles",
               $time, portB ? "B" : "A", doneTimeout);
      failures++;
    end else if (checkData) begin
      checkValue(portB ? "rspB.rdata" : "rspA.rdata", got, expd);
    end
  endtask

  // Done must never pulse on a port without a request
  always @(negedge RST) begin
    if (rspA.done && !pendA) begin
      $display("Unexpected done on port A at %0t ns with no request outstanding", $time);
      failures++;
    end
    if (rspB.done && !pendB) begin
      $display("Unexpected done on port B at %0t ns with no request outstanding", $time);
      failures++;
    end
  end

  initial begin
    int fd;
    int n;
    int lineNo;
    string line;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    logic [addrBits-1:0] idx;
    logic [addrBits-1:0] contAddr;
    logic contend;
    logic [31:0] contExp;
    dramPkg::memReq req;
    dramPkg::memReq contReq;
    RST = 1'b0;
    CK = 1'b1;
    validA = 1'b0;
    validB = 1'b0;
    reqA = '0;
    reqB = '0;
    pendA = 1'b0;
    pendB = 1'b0;
    mismatches = 0;
    failures = 0;
    rngState = 32'hc7c1;
    contAddr = '0;
    for (int i = 0; i < memWords; i++) refMem[i] = '0;
    repeat (2) @(posedge RST);
    CK <= 1'b0;
    fd = $fopen("verification/memGolden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file verification/memGolden.txt");
      failures++;
    end else begin
      lineNo = 0;
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        lineNo++;
        if (n > 0) n = $sscanf(line, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
        if (n == 6) begin
          req.write = f1[0];
          req.byteEn = f2[3:0];
          req.addr = f3[15:0];
          req.wdata = f4;
          idx = f3[addrBits-1:0];
          if (!req.write && refMem[idx] !== f5) begin
            $display("Golden line %0d expects %h at address %h but the reference holds %h",
                     lineNo, f5, idx, refMem[idx]);
            failures++;
          end
          rngState = nextRandom(rngState);
          contend = rngState[3] && !(req.write && idx == contAddr); // Other port reads too
          contReq = '0;
          contReq.byteEn = 4'hf;
          contReq.addr[addrBits-1:0] = contAddr;
          contExp = refMem[contAddr];
          if (req.write) refMem[idx] = mergeBytes(refMem[idx], req.wdata, req.byteEn);
          if (contend) begin
            fork
              doTransaction(f0[0], req, f5, !req.write);
              doTransaction(!f0[0], contReq, contExp, 1'b1);
            join
          end else begin
            doTransaction(f0[0], req, f5, !req.write);
          end
          if (req.write) contAddr = idx;
        end
      end
      $fclose(fd);
    end
    repeat (4) @(posedge RST); // Let stray done pulses show
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/memGolden.txt */
# port write byteEn addr wdata expected, all hex, one transaction per line
# port 0 is A and 1 is B; expected read data is checked on reads only
0 0 f 023 00000000 00000000
1 0 f 1ff 00000000 00000000
0 1 f 023 11223344 00000000
0 0 f 023 00000000 11223344
1 1 f 043 a5a5a5a5 00000000
1 0 f 043 00000000 a5a5a5a5
0 0 f 023 00000000 11223344
0 1 5 023 deadbeef 00000000
0 0 f 023 00000000 11ad33ef
1 1 a 043 12345678 00000000
1 0 f 043 00000000 12a556a5
0 1 f 0aa cafef00d 00000000
1 0 f 0aa 00000000 cafef00d
0 0 f 043 00000000 12a556a5
1 0 f 023 00000000 11ad33ef
0 1 1 000 000000ff 00000000
1 0 f 000 00000000 000000ff
1 1 f 1e0 89abcdef 00000000
0 0 f 1e0 00000000 89abcdef
0 1 8 1e0 7f000000 00000000
1 0 f 1e0 00000000 7fabcdef
0 0 f 0aa 00000000 cafef00d

/* files.f */
rtl/dramPkg.sv
rtl/dramDevice.sv
rtl/dramSequencer.sv
rtl/portArbiter.sv
rtl/memSubsystem.sv
verification/memSubsystemTb.sv

/* Makefile */
# Verilator build and run of the shared DRAM subsystem testbench

TOP = memSubsystemTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
